// ==== design/mps_consts.svh ====
`ifndef MPS_CONSTS_SVH
`define MPS_CONSTS_SVH

// number of serial ports, 1 to 16
`define MPS_NUM_PORTS 2

// bit period in core_clk cycles out of reset
`define MPS_DEFAULT_DIV 16'd16

// byte offsets inside the 16-byte window of one port
// port index is addr[7:4], register is addr[3:2]
`define MPS_REG_DATA 4'h0
`define MPS_REG_CTRL 4'h4
`define MPS_REG_STAT 4'h8

`endif

// ==== design/mps_pkg.sv ====
package mps_pkg;

	// register select within a port window, offset 12 is unused
	typedef enum logic [1:0] {
		REG_DATA = 2'd0,
		REG_CTRL = 2'd1,
		REG_STAT = 2'd2,
		REG_NONE = 2'd3
	} mps_reg_e;

	// data register write
	typedef struct packed {
		logic [23:0] unused;
		logic [7:0]  tx_byte;
	} mps_data_view_t;

	// control register write
	typedef struct packed {
		logic        rx_irq_en;
		logic [14:0] rsvd;
		logic [15:0] divisor;
	} mps_ctrl_view_t;

	// one write word, read as data or control depending on reg select
	typedef union packed {
		mps_data_view_t data;
		mps_ctrl_view_t ctrl;
	} mps_wdata_u;

endpackage

// ==== design/mps_axi_decode.sv ====
`include "mps_consts.svh"

module mps_axi_decode (
	input  logic                      core_clk,
	input  logic                      ext_rst,
	// write address / write data
	input  logic                      awvalid_i,
	input  logic [31:0]               awaddr_i,
	output logic                      awready_o,
	input  logic                      wvalid_i,
	input  logic [31:0]               wdata_i,
	output logic                      wready_o,
	// write response
	output logic                      bvalid_o,
	output logic [1:0]                bresp_o,
	input  logic                      bready_i,
	// read address / read response
	input  logic                      arvalid_i,
	input  logic [31:0]               araddr_i,
	output logic                      arready_o,
	output logic                      rvalid_o,
	output logic [1:0]                rresp_o,
	input  logic                      rready_i,
	// to the port engines
	output logic [`MPS_NUM_PORTS-1:0] port_wr_o,
	output logic [`MPS_NUM_PORTS-1:0] port_rd_o,
	output mps_pkg::mps_reg_e         reg_sel_o,
	output mps_pkg::mps_wdata_u       wdata_o,
	// to the read collector
	output logic                      rd_pulse_o,
	output logic [3:0]                rd_port_o,
	output mps_pkg::mps_reg_e         rd_reg_o,
	output logic                      rd_err_o
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic              bvalid_q;
	logic [1:0]        bresp_q;
	logic              rvalid_q;
	logic [1:0]        rresp_q;
	logic              rd_accept;
	logic              wr_accept;
	logic [3:0]        wr_port;
	logic [3:0]        rd_port;
	mps_pkg::mps_reg_e wr_reg;
	mps_pkg::mps_reg_e rd_reg;
	logic              wr_err;
	logic              rd_err;

	function automatic mps_pkg::mps_reg_e reg_decode(input logic [3:0] offset);
		case ({offset[3:2], 2'b00})
			`MPS_REG_DATA: reg_decode = mps_pkg::REG_DATA;
			`MPS_REG_CTRL: reg_decode = mps_pkg::REG_CTRL;
			`MPS_REG_STAT: reg_decode = mps_pkg::REG_STAT;
			default:       reg_decode = mps_pkg::REG_NONE;
		endcase
	endfunction

	// port beyond the build or hole at offset 12
	function automatic logic addr_err(input logic [3:0] port, input mps_pkg::mps_reg_e sel);
		addr_err = ({1'b0, port} >= 5'(`MPS_NUM_PORTS)) || (sel == mps_pkg::REG_NONE);
	endfunction

	assign wr_port = awaddr_i[7:4];
	assign rd_port = araddr_i[7:4];
	assign wr_reg  = reg_decode(awaddr_i[3:0]);
	assign rd_reg  = reg_decode(araddr_i[3:0]);
	assign wr_err  = addr_err(wr_port, wr_reg);
	assign rd_err  = addr_err(rd_port, rd_reg);

	// reads win when both channels ask in one cycle
	assign rd_accept = arvalid_i && !rvalid_q;
	assign wr_accept = awvalid_i && wvalid_i && !bvalid_q && !rd_accept;

	assign arready_o = rd_accept;
	assign awready_o = wr_accept;
	assign wready_o  = wr_accept;

	// one-hot strobes, only for legal addresses
	always_comb begin
		for (int i = 0; i < `MPS_NUM_PORTS; i++) begin
			port_wr_o[i] = wr_accept && !wr_err && (wr_port == 4'(i));
			port_rd_o[i] = rd_accept && !rd_err && (rd_port == 4'(i));
		end
	end

	assign reg_sel_o = rd_accept ? rd_reg : wr_reg;
	assign wdata_o   = wdata_i; // strobes are ignored

	assign rd_pulse_o = rd_accept;
	assign rd_port_o  = rd_port;
	assign rd_reg_o   = rd_reg;
	assign rd_err_o   = rd_err;

	// B channel
	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			bvalid_q <= 1'b0;
			bresp_q  <= RESP_OKAY;
		end else if (wr_accept) begin
			bvalid_q <= 1'b1;
			bresp_q  <= wr_err ? RESP_SLVERR : RESP_OKAY;
		end else if (bready_i) begin
			bvalid_q <= 1'b0;
		end
	end

	// R channel, data comes from the collector
	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			rvalid_q <= 1'b0;
			rresp_q  <= RESP_OKAY;
		end else if (rd_accept) begin
			rvalid_q <= 1'b1;
			rresp_q  <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end else if (rready_i) begin
			rvalid_q <= 1'b0;
		end
	end

	assign bvalid_o = bvalid_q;
	assign bresp_o  = bresp_q;
	assign rvalid_o = rvalid_q;
	assign rresp_o  = rresp_q;

	a_bvalid_hold: assert property (@(posedge core_clk) disable iff (ext_rst)
		bvalid_o && !bready_i |=> bvalid_o)
		else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge core_clk) disable iff (ext_rst)
		rvalid_o && !rready_i |=> rvalid_o && $stable(rresp_o))
		else $error("rvalid dropped or rresp changed before rready");

	a_wr_onehot: assert property (@(posedge core_clk) disable iff (ext_rst)
		$onehot0(port_wr_o))
		else $error("more than one port write strobe");

endmodule

// ==== design/mps_uart_port.sv ====
`include "mps_consts.svh"

module mps_uart_port (
	input  logic                core_clk,
	input  logic                ext_rst,
	input  logic                wr_i,
	input  logic                rd_i,
	input  mps_pkg::mps_reg_e   reg_sel_i,
	input  mps_pkg::mps_wdata_u wdata_i,
	input  logic                rxd_i,
	output logic                txd_o,
	output logic [7:0]          rx_byte_o,
	output logic                rx_valid_o,
	output logic                rx_overrun_o,
	output logic                tx_busy_o,
	output logic [15:0]         divisor_o,
	output logic                rx_irq_en_o
);

	localparam logic [1:0] RX_IDLE  = 2'd0;
	localparam logic [1:0] RX_START = 2'd1;
	localparam logic [1:0] RX_DATA  = 2'd2;
	localparam logic [1:0] RX_STOP  = 2'd3;

	logic [15:0] divisor_q;
	logic        rx_irq_en_q;

	logic [15:0] tx_cnt;
	logic [3:0]  tx_bits;
	logic [9:0]  tx_shift;
	logic        tx_busy_q;
	logic        tx_load;
	logic        tx_tick;

	logic [1:0]  rxd_sync;
	logic        rx_s;
	logic [1:0]  rx_state;
	logic [15:0] rx_cnt;
	logic [2:0]  rx_bits;
	logic [7:0]  rx_shift;
	logic [7:0]  rx_byte_q;
	logic        rx_valid_q;
	logic        rx_overrun_q;
	logic [15:0] half_div;
	logic        rx_tick_half;
	logic        rx_tick_full;
	logic        rx_done;
	logic        rx_clr;

	// control register
	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			divisor_q   <= `MPS_DEFAULT_DIV;
			rx_irq_en_q <= 1'b0;
		end else if (wr_i && reg_sel_i == mps_pkg::REG_CTRL) begin
			divisor_q   <= wdata_i.ctrl.divisor;
			rx_irq_en_q <= wdata_i.ctrl.rx_irq_en;
		end
	end

	// writes while busy are dropped
	assign tx_load = wr_i && reg_sel_i == mps_pkg::REG_DATA && !tx_busy_q;
	assign tx_tick = ({1'b0, tx_cnt} + 17'd1) >= {1'b0, divisor_q};

	// stop, data lsb first, start; shifts ones in so idle line stays high
	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			tx_shift  <= '1;
			tx_busy_q <= 1'b0;
			tx_cnt    <= '0;
			tx_bits   <= '0;
		end else if (tx_load) begin
			tx_shift  <= {1'b1, wdata_i.data.tx_byte, 1'b0};
			tx_busy_q <= 1'b1;
			tx_cnt    <= '0;
			tx_bits   <= '0;
		end else if (tx_busy_q) begin
			if (tx_tick) begin
				tx_cnt   <= '0;
				tx_shift <= {1'b1, tx_shift[9:1]};
				tx_bits  <= tx_bits + 4'd1;
				if (tx_bits == 4'd9)
					tx_busy_q <= 1'b0; // end of stop bit
			end else begin
				tx_cnt <= tx_cnt + 16'd1;
			end
		end
	end

	assign txd_o = tx_shift[0];

	// two-flop synchronizer, idles high
	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst)
			rxd_sync <= 2'b11;
		else
			rxd_sync <= {rxd_sync[0], rxd_i};
	end

	assign rx_s         = rxd_sync[1];
	assign half_div     = divisor_q >> 1;
	assign rx_tick_half = ({1'b0, rx_cnt} + 17'd1) >= {1'b0, half_div};
	assign rx_tick_full = ({1'b0, rx_cnt} + 17'd1) >= {1'b0, divisor_q};
	assign rx_done      = (rx_state == RX_STOP) && rx_tick_full && rx_s;

	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			rx_state <= RX_IDLE;
			rx_cnt   <= '0;
			rx_bits  <= '0;
		end else begin
			case (rx_state)
				RX_IDLE: begin
					rx_cnt <= '0;
					if (!rx_s)
						rx_state <= RX_START;
				end
				RX_START: begin
					if (rx_tick_half) begin
						rx_cnt   <= '0;
						rx_bits  <= '0;
						rx_state <= rx_s ? RX_IDLE : RX_DATA; // glitch goes back to idle
					end else begin
						rx_cnt <= rx_cnt + 16'd1;
					end
				end
				RX_DATA: begin
					if (rx_tick_full) begin
						rx_cnt  <= '0;
						rx_bits <= rx_bits + 3'd1;
						if (rx_bits == 3'd7)
							rx_state <= RX_STOP;
					end else begin
						rx_cnt <= rx_cnt + 16'd1;
					end
				end
				default: begin
					// mid stop bit, a low line drops the frame
					if (rx_tick_full)
						rx_state <= RX_IDLE;
					else
						rx_cnt <= rx_cnt + 16'd1;
				end
			endcase
		end
	end

	always_ff @(posedge core_clk) begin
		if (rx_state == RX_DATA && rx_tick_full)
			rx_shift <= {rx_s, rx_shift[7:1]};
		if (rx_done)
			rx_byte_q <= rx_shift;
	end

	assign rx_clr = rd_i && reg_sel_i == mps_pkg::REG_DATA;

	// new byte beats a clearing read in the same cycle
	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst) begin
			rx_valid_q   <= 1'b0;
			rx_overrun_q <= 1'b0;
		end else if (rx_done) begin
			rx_valid_q   <= 1'b1;
			rx_overrun_q <= (rx_valid_q || rx_overrun_q) && !rx_clr;
		end else if (rx_clr) begin
			rx_valid_q   <= 1'b0;
			rx_overrun_q <= 1'b0;
		end
	end

	assign rx_byte_o    = rx_byte_q;
	assign rx_valid_o   = rx_valid_q;
	assign rx_overrun_o = rx_overrun_q;
	assign tx_busy_o    = tx_busy_q;
	assign divisor_o    = divisor_q;
	assign rx_irq_en_o  = rx_irq_en_q;

	a_tx_idle_high: assert property (@(posedge core_clk) disable iff (ext_rst)
		!tx_busy_o |-> txd_o)
		else $error("txd low while transmitter idle");

endmodule

// ==== design/mps_result.sv ====
`include "mps_consts.svh"

module mps_result (
	input  logic                            core_clk,
	input  logic                            ext_rst,
	input  logic                            rd_pulse_i,
	input  logic [3:0]                      rd_port_i,
	input  mps_pkg::mps_reg_e               rd_reg_i,
	input  logic                            rd_err_i,
	input  logic [`MPS_NUM_PORTS-1:0][7:0]  rx_byte_i,
	input  logic [`MPS_NUM_PORTS-1:0]       rx_valid_i,
	input  logic [`MPS_NUM_PORTS-1:0]       rx_overrun_i,
	input  logic [`MPS_NUM_PORTS-1:0]       tx_busy_i,
	input  logic [`MPS_NUM_PORTS-1:0][15:0] divisor_i,
	input  logic [`MPS_NUM_PORTS-1:0]       rx_irq_en_i,
	output logic [31:0]                     rdata_o,
	output logic                            intr_request_o
);

	logic [7:0]  sel_byte;
	logic        sel_valid;
	logic        sel_overrun;
	logic        sel_busy;
	logic [15:0] sel_div;
	logic        sel_irq_en;
	logic [31:0] rd_word;
	logic [31:0] rdata_q;
	logic        intr_q;

	// pick the addressed port
	always_comb begin
		sel_byte    = '0;
		sel_valid   = 1'b0;
		sel_overrun = 1'b0;
		sel_busy    = 1'b0;
		sel_div     = '0;
		sel_irq_en  = 1'b0;
		for (int i = 0; i < `MPS_NUM_PORTS; i++) begin
			if (rd_port_i == 4'(i)) begin
				sel_byte    = rx_byte_i[i];
				sel_valid   = rx_valid_i[i];
				sel_overrun = rx_overrun_i[i];
				sel_busy    = tx_busy_i[i];
				sel_div     = divisor_i[i];
				sel_irq_en  = rx_irq_en_i[i];
			end
		end
	end

	always_comb begin
		case (rd_reg_i)
			mps_pkg::REG_DATA: rd_word = {24'b0, sel_byte};
			mps_pkg::REG_CTRL: rd_word = {sel_irq_en, 15'b0, sel_div};
			mps_pkg::REG_STAT: rd_word = {29'b0, sel_overrun, sel_valid, sel_busy};
			default:           rd_word = '0;
		endcase
		if (rd_err_i)
			rd_word = '0;
	end

	// held until the next accepted read
	always_ff @(posedge core_clk) begin
		if (rd_pulse_i)
			rdata_q <= rd_word;
	end

	always_ff @(posedge core_clk or posedge ext_rst) begin
		if (ext_rst)
			intr_q <= 1'b0;
		else
			intr_q <= |(rx_valid_i & rx_irq_en_i); // any enabled port with a byte
	end

	assign rdata_o        = rdata_q;
	assign intr_request_o = intr_q;

endmodule

// ==== design/mps_top.sv ====
`include "mps_consts.svh"

module mps_top (
	input  logic                      core_clk,
	input  logic                      ext_rst,
	input  logic                      awvalid_i,
	input  logic [31:0]               awaddr_i,
	output logic                      awready_o,
	input  logic                      wvalid_i,
	input  logic [31:0]               wdata_i,
	output logic                      wready_o,
	output logic                      bvalid_o,
	output logic [1:0]                bresp_o,
	input  logic                      bready_i,
	input  logic                      arvalid_i,
	input  logic [31:0]               araddr_i,
	output logic                      arready_o,
	output logic                      rvalid_o,
	output logic [1:0]                rresp_o,
	input  logic                      rready_i,
	output logic [31:0]               rdata_o,
	output logic                      intr_request_o,
	input  logic [`MPS_NUM_PORTS-1:0] rxd_i,
	output logic [`MPS_NUM_PORTS-1:0] txd_o
);

	// decoder to ports
	logic [`MPS_NUM_PORTS-1:0]       port_wr;
	logic [`MPS_NUM_PORTS-1:0]       port_rd;
	mps_pkg::mps_reg_e               reg_sel;
	mps_pkg::mps_wdata_u             wdata;

	// decoder to collector
	logic                            rd_pulse;
	logic [3:0]                      rd_port;
	mps_pkg::mps_reg_e               rd_reg;
	logic                            rd_err;

	// ports to collector
	logic [`MPS_NUM_PORTS-1:0][7:0]  rx_byte;
	logic [`MPS_NUM_PORTS-1:0]       rx_valid;
	logic [`MPS_NUM_PORTS-1:0]       rx_overrun;
	logic [`MPS_NUM_PORTS-1:0]       tx_busy;
	logic [`MPS_NUM_PORTS-1:0][15:0] divisor;
	logic [`MPS_NUM_PORTS-1:0]       rx_irq_en;

	mps_axi_decode u_decode (
		.core_clk   (core_clk),
		.ext_rst    (ext_rst),
		.awvalid_i  (awvalid_i),
		.awaddr_i   (awaddr_i),
		.awready_o  (awready_o),
		.wvalid_i   (wvalid_i),
		.wdata_i    (wdata_i),
		.wready_o   (wready_o),
		.bvalid_o   (bvalid_o),
		.bresp_o    (bresp_o),
		.bready_i   (bready_i),
		.arvalid_i  (arvalid_i),
		.araddr_i   (araddr_i),
		.arready_o  (arready_o),
		.rvalid_o   (rvalid_o),
		.rresp_o    (rresp_o),
		.rready_i   (rready_i),
		.port_wr_o  (port_wr),
		.port_rd_o  (port_rd),
		.reg_sel_o  (reg_sel),
		.wdata_o    (wdata),
		.rd_pulse_o (rd_pulse),
		.rd_port_o  (rd_port),
		.rd_reg_o   (rd_reg),
		.rd_err_o   (rd_err)
	);

	for (genvar i = 0; i < `MPS_NUM_PORTS; i++) begin : g_port
		mps_uart_port u_port (
			.core_clk     (core_clk),
			.ext_rst      (ext_rst),
			.wr_i         (port_wr[i]),
			.rd_i         (port_rd[i]),
			.reg_sel_i    (reg_sel),
			.wdata_i      (wdata),
			.rxd_i        (rxd_i[i]),
			.txd_o        (txd_o[i]),
			.rx_byte_o    (rx_byte[i]),
			.rx_valid_o   (rx_valid[i]),
			.rx_overrun_o (rx_overrun[i]),
			.tx_busy_o    (tx_busy[i]),
			.divisor_o    (divisor[i]),
			.rx_irq_en_o  (rx_irq_en[i])
		);
	end

	mps_result u_result (
		.core_clk       (core_clk),
		.ext_rst        (ext_rst),
		.rd_pulse_i     (rd_pulse),
		.rd_port_i      (rd_port),
		.rd_reg_i       (rd_reg),
		.rd_err_i       (rd_err),
		.rx_byte_i      (rx_byte),
		.rx_valid_i     (rx_valid),
		.rx_overrun_i   (rx_overrun),
		.tx_busy_i      (tx_busy),
		.divisor_i      (divisor),
		.rx_irq_en_i    (rx_irq_en),
		.rdata_o        (rdata_o),
		.intr_request_o (intr_request_o)
	);

endmodule

// ==== tests/mps_tb.sv ====
`include "mps_consts.svh"

module mps_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_HALF  = 4;
	localparam int MAX_WAIT  = 4000; // cycles for one handshake or level
	localparam int MAX_POLLS = 400;  // status reads before giving up
	localparam int TAB_SIZE  = 64;

	localparam logic [1:0] OKAY   = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	localparam int OP_WRITE     = 0;
	localparam int OP_READ      = 1;
	localparam int OP_WAIT_IRQ  = 2;
	localparam int OP_WAIT_STAT = 3;

	localparam logic [31:0] CTRL_RESET = {16'b0, `MPS_DEFAULT_DIV};
	localparam logic [31:0] CTRL_FAST  = 32'h8000_0008; // irq on, 8 cycles per bit
	localparam logic [31:0] STAT_RX    = 32'h2;
	localparam logic [31:0] STAT_OVR   = 32'h6;        // rx valid and overrun

	logic                      core_clk;
	logic                      ext_rst;
	logic                      awvalid;
	logic [31:0]               awaddr;
	logic                      awready;
	logic                      wvalid;
	logic [31:0]               wdata;
	logic                      wready;
	logic                      bvalid;
	logic [1:0]                bresp;
	logic                      bready;
	logic                      arvalid;
	logic [31:0]               araddr;
	logic                      arready;
	logic                      rvalid;
	logic [1:0]                rresp;
	logic                      rready;
	logic [31:0]               rdata;
	logic                      intr_request;
	logic [`MPS_NUM_PORTS-1:0] rxd;
	logic [`MPS_NUM_PORTS-1:0] txd;

	// stimulus table
	int          op_tab   [TAB_SIZE];
	logic [31:0] addr_tab [TAB_SIZE];
	logic [31:0] data_tab [TAB_SIZE];
	logic [31:0] exp_tab  [TAB_SIZE];
	logic [1:0]  resp_tab [TAB_SIZE];
	string       name_tab [TAB_SIZE];
	int          n_entries;
	logic [7:0]  lfsr_state;

	mps_top dut (
		.core_clk       (core_clk),
		.ext_rst        (ext_rst),
		.awvalid_i      (awvalid),
		.awaddr_i       (awaddr),
		.awready_o      (awready),
		.wvalid_i       (wvalid),
		.wdata_i        (wdata),
		.wready_o       (wready),
		.bvalid_o       (bvalid),
		.bresp_o        (bresp),
		.bready_i       (bready),
		.arvalid_i      (arvalid),
		.araddr_i       (araddr),
		.arready_o      (arready),
		.rvalid_o       (rvalid),
		.rresp_o        (rresp),
		.rready_i       (rready),
		.rdata_o        (rdata),
		.intr_request_o (intr_request),
		.rxd_i          (rxd),
		.txd_o          (txd)
	);

	assign rxd = {txd[0], txd[1]}; // ports crossed like the board's spare pair

	always #CLK_HALF core_clk = !core_clk;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	// one step per bit taken, msb first
	function automatic logic [7:0] lfsr_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr_state[7]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return b;
	endfunction

	function automatic logic [31:0] reg_addr(input int port, input logic [3:0] off);
		return {24'b0, 4'(port), off};
	endfunction

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
			output logic [1:0] resp, input string name);
		int cnt;
		@(negedge core_clk);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		cnt = 0;
		#1; // ready follows valid within the cycle
		while (!awready && cnt < MAX_WAIT) begin
			@(negedge core_clk);
			#1;
			cnt++;
		end
		assert (awready)
		else fail_run($sformatf("timeout: write for %s was never accepted", name));
		check_value({name, " awready wready"}, 32'h3, 32'({awready, wready}));
		@(negedge core_clk);
		assert (bvalid)
		else fail_run($sformatf("write response for %s not one cycle after awready", name));
		check_value({name, " ready pulse"}, 0, 32'({awready, wready}));
		awvalid = 1'b0;
		wvalid  = 1'b0;
		resp    = bresp;
		bready  = 1'b1;
		@(negedge core_clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp, input string name);
		int cnt;
		@(negedge core_clk);
		araddr  = addr;
		arvalid = 1'b1;
		cnt = 0;
		#1;
		while (!arready && cnt < MAX_WAIT) begin
			@(negedge core_clk);
			#1;
			cnt++;
		end
		assert (arready)
		else fail_run($sformatf("timeout: read for %s was never accepted", name));
		@(negedge core_clk);
		assert (rvalid)
		else fail_run($sformatf("read response for %s not one cycle after arready", name));
		check_value({name, " arready pulse"}, 0, 32'(arready));
		arvalid = 1'b0;
		data    = rdata;
		resp    = rresp;
		rready  = 1'b1;
		@(negedge core_clk);
		rready = 1'b0;
	endtask

	task automatic wait_irq(input logic level, input string name);
		int cnt;
		cnt = 0;
		while (intr_request !== level && cnt < MAX_WAIT) begin
			@(negedge core_clk);
			cnt++;
		end
		assert (intr_request === level)
		else fail_run($sformatf("timeout: %s, interrupt request never went to %0b", name, level));
	endtask

	// polls a status register until it matches
	task automatic wait_status(input logic [31:0] addr, input logic [31:0] exp, input string name);
		logic [31:0] got;
		logic [1:0]  resp;
		int          polls;
		polls = 0;
		got   = ~exp;
		while (got !== exp && polls < MAX_POLLS) begin
			axi_read(addr, got, resp, name);
			check_value({name, " rresp"}, 32'(OKAY), 32'(resp));
			polls++;
		end
		assert (got === exp)
		else fail_run($sformatf("timeout: %s, status stuck at %h instead of %h", name, got, exp));
	endtask

	task automatic add_entry(input int op, input logic [31:0] addr, input logic [31:0] data,
			input logic [31:0] exp, input logic [1:0] resp, input string name);
		op_tab[n_entries]   = op;
		addr_tab[n_entries] = addr;
		data_tab[n_entries] = data;
		exp_tab[n_entries]  = exp;
		resp_tab[n_entries] = resp;
		name_tab[n_entries] = name;
		n_entries++;
	endtask

	task automatic build_table();
		logic [7:0]  tx [5];
		logic [31:0] p0_data;
		logic [31:0] p0_ctrl;
		logic [31:0] p0_stat;
		logic [31:0] p1_data;
		logic [31:0] p1_ctrl;
		logic [31:0] p1_stat;
		for (int i = 0; i < 5; i++)
			tx[i] = lfsr_byte();
		p0_data = reg_addr(0, `MPS_REG_DATA);
		p0_ctrl = reg_addr(0, `MPS_REG_CTRL);
		p0_stat = reg_addr(0, `MPS_REG_STAT);
		p1_data = reg_addr(1, `MPS_REG_DATA);
		p1_ctrl = reg_addr(1, `MPS_REG_CTRL);
		p1_stat = reg_addr(1, `MPS_REG_STAT);

		add_entry(OP_READ, p0_ctrl, 0, CTRL_RESET, OKAY, "p0 ctrl reset");
		add_entry(OP_READ, p1_ctrl, 0, CTRL_RESET, OKAY, "p1 ctrl reset");
		add_entry(OP_READ, p0_stat, 0, 0, OKAY, "p0 stat reset");
		add_entry(OP_READ, p1_stat, 0, 0, OKAY, "p1 stat reset");
		add_entry(OP_WAIT_IRQ, 0, 0, 0, OKAY, "irq low after reset");

		// irq still disabled, default divisor
		add_entry(OP_WRITE, p0_data, {24'b0, tx[0]}, 0, OKAY, "p0 send, irq off");
		add_entry(OP_WAIT_STAT, p1_stat, 0, STAT_RX, OKAY, "p1 rx valid, irq off");
		add_entry(OP_WAIT_IRQ, 0, 0, 0, OKAY, "irq stays low when disabled");
		add_entry(OP_READ, p1_data, 0, {24'b0, tx[0]}, OKAY, "p1 data, irq off");
		add_entry(OP_READ, p1_stat, 0, 0, OKAY, "p1 stat cleared, irq off");
		add_entry(OP_WAIT_STAT, p0_stat, 0, 0, OKAY, "p0 tx done, irq off");

		add_entry(OP_WRITE, p0_ctrl, CTRL_FAST, 0, OKAY, "p0 ctrl write");
		add_entry(OP_WRITE, p1_ctrl, CTRL_FAST, 0, OKAY, "p1 ctrl write");
		add_entry(OP_READ, p0_ctrl, 0, CTRL_FAST, OKAY, "p0 ctrl readback");
		add_entry(OP_READ, p1_ctrl, 0, CTRL_FAST, OKAY, "p1 ctrl readback");

		// port 0 to port 1
		add_entry(OP_WRITE, p0_data, {24'b0, tx[1]}, 0, OKAY, "p0 send");
		add_entry(OP_WAIT_STAT, p1_stat, 0, STAT_RX, OKAY, "p1 rx valid");
		add_entry(OP_WAIT_IRQ, 0, 0, 1, OKAY, "irq on p1 byte");
		add_entry(OP_READ, p1_data, 0, {24'b0, tx[1]}, OKAY, "p1 data");
		add_entry(OP_WAIT_IRQ, 0, 0, 0, OKAY, "irq off after p1 read");
		add_entry(OP_READ, p1_stat, 0, 0, OKAY, "p1 stat cleared");
		add_entry(OP_WAIT_STAT, p0_stat, 0, 0, OKAY, "p0 tx done");

		// port 1 to port 0
		add_entry(OP_WRITE, p1_data, {24'b0, tx[2]}, 0, OKAY, "p1 send");
		add_entry(OP_WAIT_STAT, p0_stat, 0, STAT_RX, OKAY, "p0 rx valid");
		add_entry(OP_WAIT_IRQ, 0, 0, 1, OKAY, "irq on p0 byte");
		add_entry(OP_READ, p0_data, 0, {24'b0, tx[2]}, OKAY, "p0 data");
		add_entry(OP_WAIT_IRQ, 0, 0, 0, OKAY, "irq off after p0 read");
		add_entry(OP_READ, p0_stat, 0, 0, OKAY, "p0 stat cleared");
		add_entry(OP_WAIT_STAT, p1_stat, 0, 0, OKAY, "p1 tx done");

		// two bytes, no read in between
		add_entry(OP_WRITE, p0_data, {24'b0, tx[3]}, 0, OKAY, "p0 send first");
		add_entry(OP_WAIT_STAT, p1_stat, 0, STAT_RX, OKAY, "p1 first byte held");
		add_entry(OP_WAIT_STAT, p0_stat, 0, 0, OKAY, "p0 first tx done");
		add_entry(OP_WRITE, p0_data, {24'b0, tx[4]}, 0, OKAY, "p0 send second");
		add_entry(OP_WAIT_STAT, p1_stat, 0, STAT_OVR, OKAY, "p1 overrun");
		add_entry(OP_READ, p1_data, 0, {24'b0, tx[4]}, OKAY, "p1 data after overrun");
		add_entry(OP_READ, p1_stat, 0, 0, OKAY, "p1 stat after overrun read");
		add_entry(OP_WAIT_STAT, p0_stat, 0, 0, OKAY, "p0 second tx done");
		add_entry(OP_WAIT_IRQ, 0, 0, 0, OKAY, "irq off after overrun");

		// out of range port and the hole at offset 12
		add_entry(OP_READ, 32'h20, 0, 0, SLVERR, "read port 2");
		add_entry(OP_READ, 32'h0C, 0, 0, SLVERR, "read offset 12");
		add_entry(OP_WRITE, 32'h24, 32'h0000_0003, 0, SLVERR, "write port 2 ctrl");
		add_entry(OP_WRITE, 32'h20, 32'h0000_0055, 0, SLVERR, "write port 2 data");
		add_entry(OP_WRITE, 32'h0C, 32'h0000_0004, 0, SLVERR, "write p0 offset 12");
		add_entry(OP_WRITE, 32'h1C, 32'h0000_0005, 0, SLVERR, "write p1 offset 12");
		add_entry(OP_WRITE, p0_stat, 32'hFFFF_FFFF, 0, OKAY, "write p0 stat");
		add_entry(OP_READ, p0_ctrl, 0, CTRL_FAST, OKAY, "p0 ctrl after bad writes");
		add_entry(OP_READ, p1_ctrl, 0, CTRL_FAST, OKAY, "p1 ctrl after bad writes");
		add_entry(OP_READ, p0_stat, 0, 0, OKAY, "p0 stat after bad writes");
		add_entry(OP_READ, p1_stat, 0, 0, OKAY, "p1 stat after bad writes");
	endtask

	task automatic run_entry(input int i);
		logic [31:0] got;
		logic [1:0]  resp;
		case (op_tab[i])
			OP_WRITE: begin
				axi_write(addr_tab[i], data_tab[i], resp, name_tab[i]);
				check_value({name_tab[i], " bresp"}, 32'(resp_tab[i]), 32'(resp));
			end
			OP_READ: begin
				axi_read(addr_tab[i], got, resp, name_tab[i]);
				check_value({name_tab[i], " rresp"}, 32'(resp_tab[i]), 32'(resp));
				check_value(name_tab[i], exp_tab[i], got);
			end
			OP_WAIT_IRQ: wait_irq(exp_tab[i][0], name_tab[i]);
			default:     wait_status(addr_tab[i], exp_tab[i], name_tab[i]);
		endcase
	endtask

	initial begin
		core_clk   = 1'b0;
		ext_rst    = 1'b1;
		awvalid    = 1'b0;
		awaddr     = '0;
		wvalid     = 1'b0;
		wdata      = '0;
		bready     = 1'b0;
		arvalid    = 1'b0;
		araddr     = '0;
		rready     = 1'b0;
		lfsr_state = 8'd68;
		n_entries  = 0;
		build_table();

		repeat (4) @(negedge core_clk);
		ext_rst = 1'b0;
		@(negedge core_clk);
		check_value("txd idle after reset", {`MPS_NUM_PORTS{1'b1}}, 32'(txd));
		check_value("bvalid after reset", 0, 32'(bvalid));
		check_value("rvalid after reset", 0, 32'(rvalid));
		check_value("irq after reset", 0, 32'(intr_request));

		for (int i = 0; i < n_entries; i++)
			run_entry(i);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+design
design/mps_pkg.sv
design/mps_axi_decode.sv
design/mps_uart_port.sv
design/mps_result.sv
design/mps_top.sv
tests/mps_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module mps_tb \
	-f vlog.f -Mdir obj_dir -o mps_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/mps_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
	exit 0
fi
echo "pass message not found"
exit 1
